// File: src/mpmem_pkg.sv
package mpmem_pkg;

  //////////////////////////////
  // Geometry.
  //////////////////////////////

  localparam int NUM_BANKS = 4;
  localparam int BANK_BITS = 2;
  localparam int ROW_BITS  = 6;
  localparam int DATA_BITS = 16;

  // Up to 8 write or read ports.
  localparam int PORT_BITS = 3;

  //////////////////////////////
  // Port records.
  //////////////////////////////

  typedef struct packed {
    logic                 en;
    logic [BANK_BITS-1:0] bank;
    logic [ROW_BITS-1:0]  row;
    logic [DATA_BITS-1:0] data;
  } wr_req_t;

  typedef struct packed {
    logic                 en;
    logic [BANK_BITS-1:0] bank;
    logic [ROW_BITS-1:0]  row;
  } rd_req_t;

  typedef struct packed {
    logic                 vld;
    logic [DATA_BITS-1:0] data;
  } rd_rsp_t;

  // First offending write pair, highest and lowest port of one bank.
  typedef struct packed {
    logic [PORT_BITS-1:0] port_hi;
    logic [PORT_BITS-1:0] port_lo;
    logic [BANK_BITS-1:0] bank;
  } conflict_t;

endpackage

// File: src/bank_ram.sv
module bank_ram #(
  parameter int NUM_RD   = 2,
  parameter int RD_DELAY = 2
) (
  input  logic                                           clk,
  input  logic                                           rst_n,
  input  logic                                           wr_en,
  input  logic [mpmem_pkg::ROW_BITS-1:0]                 wr_row,
  input  logic [mpmem_pkg::DATA_BITS-1:0]                wr_data,
  input  logic [NUM_RD-1:0][mpmem_pkg::ROW_BITS-1:0]     rd_row,
  output logic [NUM_RD-1:0][mpmem_pkg::DATA_BITS-1:0]    rd_data
);

  localparam int DEPTH = 2 ** mpmem_pkg::ROW_BITS;

  // One write port; every read port sees its own copy of the array.
  logic [mpmem_pkg::DATA_BITS-1:0] mem [DEPTH];

  logic [NUM_RD-1:0][RD_DELAY-1:0][mpmem_pkg::DATA_BITS-1:0] rd_pipe;

  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem[wr_row] <= wr_data;
    end
  end

  //////////////////////////////
  // Read chains.
  //////////////////////////////

  // Stage 0 captures the word before a same-edge write lands.
  always_ff @(posedge clk) begin
    for (int p = 0; p < NUM_RD; p++) begin
      rd_pipe[p][0] <= mem[rd_row[p]];
      for (int s = 1; s < RD_DELAY; s++) begin
        rd_pipe[p][s] <= rd_pipe[p][s-1];
      end
    end
  end

  always_comb begin
    for (int p = 0; p < NUM_RD; p++) begin
      rd_data[p] = rd_pipe[p][RD_DELAY-1];
    end
  end

  a_wr_row_known: assert property (
    @(posedge clk) disable iff (!rst_n)
    wr_en |-> !$isunknown(wr_row)
  ) else $error("bank write with unknown row");

endmodule

// File: src/write_crossbar.sv
module write_crossbar #(
  parameter int NUM_WR = 4
) (
  input  logic                                                   clk,
  input  logic                                                   rst_n,
  input  mpmem_pkg::wr_req_t [NUM_WR-1:0]                        wr_req,
  output logic [mpmem_pkg::NUM_BANKS-1:0]                        bank_wr_en,
  output logic [mpmem_pkg::NUM_BANKS-1:0][mpmem_pkg::ROW_BITS-1:0]  bank_wr_row,
  output logic [mpmem_pkg::NUM_BANKS-1:0][mpmem_pkg::DATA_BITS-1:0] bank_wr_data
);

  // Per bank, which enabled ports aim at it.
  logic [mpmem_pkg::NUM_BANKS-1:0][NUM_WR-1:0] bank_hit;

  //////////////////////////////
  // Priority select.
  //////////////////////////////

  // Walk from the top port down so the lowest port is written last and wins.
  always_comb begin
    bank_wr_en   = '0;
    bank_wr_row  = '0;
    bank_wr_data = '0;
    for (int w = NUM_WR - 1; w >= 0; w--) begin
      if (wr_req[w].en) begin
        bank_wr_en[wr_req[w].bank]   = 1'b1;
        bank_wr_row[wr_req[w].bank]  = wr_req[w].row;
        bank_wr_data[wr_req[w].bank] = wr_req[w].data;
      end
    end
  end

  for (genvar b = 0; b < mpmem_pkg::NUM_BANKS; b++) begin : g_bank
    for (genvar w = 0; w < NUM_WR; w++) begin : g_port
      assign bank_hit[b][w] = wr_req[w].en &&
                              (wr_req[w].bank == mpmem_pkg::BANK_BITS'(b));
    end

    a_bank_en: assert property (
      @(posedge clk) disable iff (!rst_n)
      bank_wr_en[b] == (|bank_hit[b])
    ) else $error("bank %0d write enable does not match requests", b);
  end

endmodule

// File: src/read_pipeline.sv
module read_pipeline #(
  parameter int NUM_RD   = 2,
  parameter int RD_DELAY = 2
) (
  input  logic                                   clk,
  input  logic                                   rst_n,
  input  mpmem_pkg::rd_req_t [NUM_RD-1:0]        rd_req,
  output logic [mpmem_pkg::NUM_BANKS-1:0][NUM_RD-1:0][mpmem_pkg::ROW_BITS-1:0]  bank_rd_row,
  input  logic [mpmem_pkg::NUM_BANKS-1:0][NUM_RD-1:0][mpmem_pkg::DATA_BITS-1:0] bank_rd_data,
  output mpmem_pkg::rd_rsp_t [NUM_RD-1:0]        rd_rsp
);

  logic [NUM_RD-1:0][RD_DELAY-1:0]                           en_pipe;
  logic [NUM_RD-1:0][RD_DELAY-1:0][mpmem_pkg::BANK_BITS-1:0] bank_pipe;

  logic [NUM_RD-1:0]                          rsp_vld;
  logic [NUM_RD-1:0][mpmem_pkg::DATA_BITS-1:0] rsp_data;

  // Every bank starts the read; the delayed bank index picks the winner.
  always_comb begin
    for (int b = 0; b < mpmem_pkg::NUM_BANKS; b++) begin
      for (int p = 0; p < NUM_RD; p++) begin
        bank_rd_row[b][p] = rd_req[p].row;
      end
    end
  end

  //////////////////////////////
  // Request delay.
  //////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      en_pipe <= '0;
    end else begin
      for (int p = 0; p < NUM_RD; p++) begin
        en_pipe[p][0] <= rd_req[p].en;
        for (int s = 1; s < RD_DELAY; s++) begin
          en_pipe[p][s] <= en_pipe[p][s-1];
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    for (int p = 0; p < NUM_RD; p++) begin
      bank_pipe[p][0] <= rd_req[p].bank;
      for (int s = 1; s < RD_DELAY; s++) begin
        bank_pipe[p][s] <= bank_pipe[p][s-1];
      end
    end
  end

  //////////////////////////////
  // Response register.
  //////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rsp_vld <= '0;
    end else begin
      for (int p = 0; p < NUM_RD; p++) begin
        rsp_vld[p] <= en_pipe[p][RD_DELAY-1];
      end
    end
  end

  always_ff @(posedge clk) begin
    for (int p = 0; p < NUM_RD; p++) begin
      rsp_data[p] <= bank_rd_data[bank_pipe[p][RD_DELAY-1]][p];
    end
  end

  always_comb begin
    for (int p = 0; p < NUM_RD; p++) begin
      rd_rsp[p].vld  = rsp_vld[p];
      rd_rsp[p].data = rsp_data[p];
    end
  end

  // Vld is launched RD_DELAY edges after the request and sampled one later.
  for (genvar p = 0; p < NUM_RD; p++) begin : g_chk
    a_vld_has_req: assert property (
      @(posedge clk) disable iff (!rst_n)
      rd_rsp[p].vld |-> $past(rd_req[p].en, RD_DELAY + 1)
    ) else $error("read port %0d vld without a request", p);
  end

endmodule

// File: src/bank_conflict_monitor.sv
module bank_conflict_monitor #(
  parameter int NUM_WR = 4
) (
  input  logic                            clk,
  input  logic                            rst_n,
  input  mpmem_pkg::wr_req_t [NUM_WR-1:0] wr_req,
  input  logic                            conflict_clr,
  output logic                            conflict,
  output mpmem_pkg::conflict_t            conflict_info
);

  // Pair j,k (k < j) enabled and aimed at one bank.
  logic [NUM_WR-1:0][NUM_WR-1:0] same_bank;
  logic                          any_pair;
  logic                          cur_hit;
  mpmem_pkg::conflict_t          cur_info;

  for (genvar j = 0; j < NUM_WR; j++) begin : g_hi
    for (genvar k = 0; k < NUM_WR; k++) begin : g_lo
      if (k < j) begin : g_pair
        assign same_bank[j][k] = wr_req[j].en && wr_req[k].en &&
                                 (wr_req[j].bank == wr_req[k].bank);
      end else begin : g_none
        assign same_bank[j][k] = 1'b0;
      end
    end
  end

  assign any_pair = |same_bank;

  //////////////////////////////
  // Record of this cycle.
  //////////////////////////////

  // Banks walked downward so the lowest conflicting bank is kept.
  always_comb begin
    logic                           found;
    logic [mpmem_pkg::PORT_BITS-1:0] lo;
    logic [mpmem_pkg::PORT_BITS-1:0] hi;
    cur_hit  = 1'b0;
    cur_info = '0;
    for (int b = mpmem_pkg::NUM_BANKS - 1; b >= 0; b--) begin
      found = 1'b0;
      lo    = '0;
      hi    = '0;
      for (int w = 0; w < NUM_WR; w++) begin
        if (wr_req[w].en && (wr_req[w].bank == mpmem_pkg::BANK_BITS'(b))) begin
          if (!found) begin
            lo = mpmem_pkg::PORT_BITS'(w);
          end
          found = 1'b1;
          hi    = mpmem_pkg::PORT_BITS'(w);
        end
      end
      if (found && (hi != lo)) begin
        cur_hit          = 1'b1;
        cur_info.port_hi = hi;
        cur_info.port_lo = lo;
        cur_info.bank    = mpmem_pkg::BANK_BITS'(b);
      end
    end
  end

  // Sticky flag; a clear with a fresh conflict reloads.
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      conflict      <= 1'b0;
      conflict_info <= '0;
    end else if (cur_hit && (!conflict || conflict_clr)) begin
      conflict      <= 1'b1;
      conflict_info <= cur_info;
    end else if (conflict_clr) begin
      conflict      <= 1'b0;
      conflict_info <= '0;
    end
  end

  a_info_order: assert property (
    @(posedge clk) disable iff (!rst_n)
    conflict |-> (conflict_info.port_hi > conflict_info.port_lo)
  ) else $error("conflict record ports out of order");

  a_rise_has_pair: assert property (
    @(posedge clk) disable iff (!rst_n)
    $rose(conflict) |-> $past(any_pair)
  ) else $error("conflict raised without a same-bank pair");

endmodule

// File: src/mpmem_top.sv
module mpmem_top #(
  parameter int NUM_WR   = 4,
  parameter int NUM_RD   = 2,
  parameter int RD_DELAY = 2
) (
  input  logic                            clk,
  input  logic                            rst_n,
  input  mpmem_pkg::wr_req_t [NUM_WR-1:0] wr_req,
  input  mpmem_pkg::rd_req_t [NUM_RD-1:0] rd_req,
  output mpmem_pkg::rd_rsp_t [NUM_RD-1:0] rd_rsp,
  input  logic                            conflict_clr,
  output logic                            conflict,
  output mpmem_pkg::conflict_t            conflict_info
);

  logic [mpmem_pkg::NUM_BANKS-1:0]                           bank_wr_en;
  logic [mpmem_pkg::NUM_BANKS-1:0][mpmem_pkg::ROW_BITS-1:0]  bank_wr_row;
  logic [mpmem_pkg::NUM_BANKS-1:0][mpmem_pkg::DATA_BITS-1:0] bank_wr_data;

  logic [mpmem_pkg::NUM_BANKS-1:0][NUM_RD-1:0][mpmem_pkg::ROW_BITS-1:0]  bank_rd_row;
  logic [mpmem_pkg::NUM_BANKS-1:0][NUM_RD-1:0][mpmem_pkg::DATA_BITS-1:0] bank_rd_data;

  write_crossbar #(.NUM_WR(NUM_WR)) u_write_crossbar (
    .clk          (clk),
    .rst_n        (rst_n),
    .wr_req       (wr_req),
    .bank_wr_en   (bank_wr_en),
    .bank_wr_row  (bank_wr_row),
    .bank_wr_data (bank_wr_data)
  );

  for (genvar b = 0; b < mpmem_pkg::NUM_BANKS; b++) begin : g_bank
    bank_ram #(.NUM_RD(NUM_RD), .RD_DELAY(RD_DELAY)) u_bank_ram (
      .clk     (clk),
      .rst_n   (rst_n),
      .wr_en   (bank_wr_en[b]),
      .wr_row  (bank_wr_row[b]),
      .wr_data (bank_wr_data[b]),
      .rd_row  (bank_rd_row[b]),
      .rd_data (bank_rd_data[b])
    );
  end

  read_pipeline #(.NUM_RD(NUM_RD), .RD_DELAY(RD_DELAY)) u_read_pipeline (
    .clk          (clk),
    .rst_n        (rst_n),
    .rd_req       (rd_req),
    .bank_rd_row  (bank_rd_row),
    .bank_rd_data (bank_rd_data),
    .rd_rsp       (rd_rsp)
  );

  // Watches the raw write ports alongside the crossbar.
  bank_conflict_monitor #(.NUM_WR(NUM_WR)) u_bank_conflict_monitor (
    .clk           (clk),
    .rst_n         (rst_n),
    .wr_req        (wr_req),
    .conflict_clr  (conflict_clr),
    .conflict      (conflict),
    .conflict_info (conflict_info)
  );

endmodule

// File: verif/mpmem_tb.sv
module mpmem_tb;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int NUM_WR      = 4;
  localparam int NUM_RD      = 2;
  localparam int RD_DELAY    = 2;
  localparam int RSP_TIMEOUT = 8;

  logic                            clk;
  logic                            rst_n;
  logic                            conflict_clr;
  logic                            conflict;
  mpmem_pkg::conflict_t            conflict_info;
  mpmem_pkg::wr_req_t [NUM_WR-1:0] wr_req;
  mpmem_pkg::rd_req_t [NUM_RD-1:0] rd_req;
  mpmem_pkg::rd_rsp_t [NUM_RD-1:0] rd_rsp;

  // Inputs for the next falling edge.
  mpmem_pkg::wr_req_t [NUM_WR-1:0] nxt_wr;
  mpmem_pkg::rd_req_t [NUM_RD-1:0] nxt_rd;
  logic                            nxt_clr;

  logic [mpmem_pkg::DATA_BITS-1:0] model_mem [mpmem_pkg::NUM_BANKS][2 ** mpmem_pkg::ROW_BITS];
  mpmem_pkg::rd_rsp_t              exp_rsp [NUM_RD][RD_DELAY+1];
  logic                            exp_flag;
  mpmem_pkg::conflict_t            exp_info;
  logic [31:0]                     rng;

  mpmem_top #(.NUM_WR(NUM_WR), .NUM_RD(NUM_RD), .RD_DELAY(RD_DELAY)) u_mpmem_top (
    .clk           (clk),
    .rst_n         (rst_n),
    .wr_req        (wr_req),
    .rd_req        (rd_req),
    .rd_rsp        (rd_rsp),
    .conflict_clr  (conflict_clr),
    .conflict      (conflict),
    .conflict_info (conflict_info)
  );

  always #20 clk = ~clk;

  function automatic logic [31:0] xorshift();
    rng = rng ^ (rng << 13);
    rng = rng ^ (rng >> 17);
    rng = rng ^ (rng << 5);
    return rng;
  endfunction

  // Word depends on bank and row.
  function automatic int fill_word(input int bank, input int row);
    logic [7:0] a;
    a = {bank[1:0], row[5:0]};
    return {16'h0, ~a, a};
  endfunction

  function automatic mpmem_pkg::wr_req_t make_wr(input int bank, input int row, input int data);
    mpmem_pkg::wr_req_t q;
    q.en   = 1'b1;
    q.bank = mpmem_pkg::BANK_BITS'(bank);
    q.row  = mpmem_pkg::ROW_BITS'(row);
    q.data = mpmem_pkg::DATA_BITS'(data);
    return q;
  endfunction

  function automatic mpmem_pkg::rd_req_t make_rd(input int bank, input int row);
    mpmem_pkg::rd_req_t q;
    q.en   = 1'b1;
    q.bank = mpmem_pkg::BANK_BITS'(bank);
    q.row  = mpmem_pkg::ROW_BITS'(row);
    return q;
  endfunction

  task automatic fail_now();
    $display("SIMULATION FAILED");
    $fatal(1, "stopped at first error");
  endtask

  task automatic check_rd_rsp(input mpmem_pkg::rd_rsp_t exp, input mpmem_pkg::rd_rsp_t got,
                              input int port);
    if (got.vld !== exp.vld || (exp.vld && got.data !== exp.data)) begin
      $display("mismatch at %0t: read port %0d expected vld %0b data %h, got vld %0b data %h",
               $time, port, exp.vld, exp.data, got.vld, got.data);
      fail_now();
    end
  endtask

  task automatic check_conflict(input logic exp_f, input mpmem_pkg::conflict_t exp_i,
                                input logic got_f, input mpmem_pkg::conflict_t got_i);
    if (got_f !== exp_f || (exp_f && got_i !== exp_i)) begin
      $display("mismatch at %0t: conflict expected %0b %p, got %0b %p",
               $time, exp_f, exp_i, got_f, got_i);
      fail_now();
    end
  endtask

  //////////////////////////////
  // Reference model.
  //////////////////////////////

  task automatic model_step();
    logic [mpmem_pkg::NUM_BANKS-1:0] taken;
    logic                            hit;
    mpmem_pkg::conflict_t            cur;
    int                              cnt;
    int                              lo;
    int                              hi;
    taken = '0;
    hit   = 1'b0;
    cur   = '0;
    // Reads take the word from before this edge's writes.
    for (int p = 0; p < NUM_RD; p++) begin
      for (int s = RD_DELAY; s > 0; s--) begin
        exp_rsp[p][s] = exp_rsp[p][s-1];
      end
      exp_rsp[p][0].vld  = nxt_rd[p].en;
      exp_rsp[p][0].data = model_mem[nxt_rd[p].bank][nxt_rd[p].row];
    end
    for (int w = 0; w < NUM_WR; w++) begin
      if (nxt_wr[w].en && !taken[nxt_wr[w].bank]) begin
        model_mem[nxt_wr[w].bank][nxt_wr[w].row] = nxt_wr[w].data;
        taken[nxt_wr[w].bank] = 1'b1;
      end
    end
    // First bank upward with two or more writers.
    for (int b = 0; b < mpmem_pkg::NUM_BANKS; b++) begin
      cnt = 0;
      lo  = 0;
      hi  = 0;
      for (int w = 0; w < NUM_WR; w++) begin
        if (nxt_wr[w].en && nxt_wr[w].bank == mpmem_pkg::BANK_BITS'(b)) begin
          if (cnt == 0) lo = w;
          hi  = w;
          cnt = cnt + 1;
        end
      end
      if (!hit && cnt > 1) begin
        hit         = 1'b1;
        cur.port_hi = mpmem_pkg::PORT_BITS'(hi);
        cur.port_lo = mpmem_pkg::PORT_BITS'(lo);
        cur.bank    = mpmem_pkg::BANK_BITS'(b);
      end
    end
    if (hit && (!exp_flag || nxt_clr)) begin
      exp_flag = 1'b1;
      exp_info = cur;
    end else if (nxt_clr) begin
      exp_flag = 1'b0;
    end
  endtask

  // Check what the last rising edge produced, then drive the staged inputs.
  task automatic cycle();
    @(negedge clk);
    for (int p = 0; p < NUM_RD; p++) begin
      check_rd_rsp(exp_rsp[p][RD_DELAY], rd_rsp[p], p);
    end
    check_conflict(exp_flag, exp_info, conflict, conflict_info);
    model_step();
    wr_req       = nxt_wr;
    rd_req       = nxt_rd;
    conflict_clr = nxt_clr;
    nxt_wr       = '0;
    nxt_rd       = '0;
    nxt_clr      = 1'b0;
  endtask

  task automatic wait_rsp(input int port);
    int n;
    n = 0;
    while (!rd_rsp[port].vld) begin
      if (n == RSP_TIMEOUT) begin
        $display("timeout waiting for a read response on port %0d", port);
        fail_now();
      end else begin
        cycle();
        n = n + 1;
      end
    end
  endtask

  initial begin
    mpmem_pkg::rd_rsp_t   want;
    mpmem_pkg::conflict_t rec;
    logic [31:0]          r;
    clk          = 1'b0;
    rst_n        = 1'b0;
    wr_req       = '0;
    rd_req       = '0;
    conflict_clr = 1'b0;
    nxt_wr       = '0;
    nxt_rd       = '0;
    nxt_clr      = 1'b0;
    exp_flag     = 1'b0;
    exp_info     = '0;
    rng          = 32'h7d7f;
    for (int p = 0; p < NUM_RD; p++) begin
      for (int s = 0; s <= RD_DELAY; s++) exp_rsp[p][s] = '0;
    end
    repeat (3) @(negedge clk);
    rst_n = 1'b1;
    for (int p = 0; p < NUM_RD; p++) check_rd_rsp('0, rd_rsp[p], p);
    check_conflict(1'b0, '0, conflict, conflict_info);

    // Fill all rows, one port per bank.
    for (int row = 0; row < 2 ** mpmem_pkg::ROW_BITS; row++) begin
      for (int w = 0; w < NUM_WR; w++) nxt_wr[w] = make_wr(w, row, fill_word(w, row));
      cycle();
    end
    want.vld = 1'b1;
    for (int i = 0; i < 8; i++) begin
      nxt_rd[0] = make_rd(i % 4, i * 7);
      nxt_rd[1] = make_rd((i + 1) % 4, i * 5 + 3);
      cycle();
      wait_rsp(0);
      want.data = mpmem_pkg::DATA_BITS'(fill_word(i % 4, i * 7));
      check_rd_rsp(want, rd_rsp[0], 0);
      want.data = mpmem_pkg::DATA_BITS'(fill_word((i + 1) % 4, i * 5 + 3));
      check_rd_rsp(want, rd_rsp[1], 1);
    end

    // Back-to-back reads; port 0 races a write to its own row.
    for (int i = 0; i < 16; i++) begin
      nxt_rd[0] = make_rd(i % 4, i);
      nxt_rd[1] = make_rd(3 - i % 4, 63 - i);
      nxt_wr[0] = make_wr(i % 4, i, 16'h5a00 + i);
      cycle();
    end
    repeat (RD_DELAY + 1) cycle();

    // Every port on one row of bank 2.
    for (int w = 0; w < NUM_WR; w++) nxt_wr[w] = make_wr(2, 5, 16'hc000 + w);
    cycle();
    nxt_rd[0] = make_rd(2, 5);
    cycle();
    wait_rsp(0);
    want.data = 16'hc000;
    check_rd_rsp(want, rd_rsp[0], 0);
    rec.port_hi = 3'd3;
    rec.port_lo = 3'd0;
    rec.bank    = 2'd2;
    check_conflict(1'b1, rec, conflict, conflict_info);
    nxt_wr[1] = make_wr(0, 1, 1);
    nxt_wr[3] = make_wr(0, 2, 2);
    cycle();
    cycle();
    check_conflict(1'b1, rec, conflict, conflict_info);
    nxt_clr = 1'b1;
    cycle();
    cycle();
    check_conflict(1'b0, rec, conflict, conflict_info);
    nxt_wr[0] = make_wr(1, 9, 7);
    nxt_wr[2] = make_wr(1, 10, 8);
    cycle();
    // Clear and a fresh pair on the same edge.
    nxt_clr   = 1'b1;
    nxt_wr[1] = make_wr(3, 4, 9);
    nxt_wr[2] = make_wr(3, 5, 10);
    cycle();
    cycle();
    rec.port_hi = 3'd2;
    rec.port_lo = 3'd1;
    rec.bank    = 2'd3;
    check_conflict(1'b1, rec, conflict, conflict_info);

    //////////////////////////////
    // Random traffic.
    //////////////////////////////
    repeat (3000) begin
      for (int w = 0; w < NUM_WR; w++) begin
        r = xorshift();
        nxt_wr[w] = make_wr(r[2:1], r[8:3], r[31:16]);
        nxt_wr[w].en = r[0];
      end
      for (int p = 0; p < NUM_RD; p++) begin
        r = xorshift();
        nxt_rd[p] = make_rd(r[2:1], r[8:3]);
        nxt_rd[p].en = r[0];
      end
      r = xorshift();
      nxt_clr = (r[3:0] == 4'd0);
      cycle();
    end
    repeat (RD_DELAY + 1) cycle();
    $display("SIMULATION PASSED");
    $finish;
  end

endmodule

// File: filelist.f
src/mpmem_pkg.sv
src/bank_ram.sv
src/write_crossbar.sv
src/read_pipeline.sv
src/bank_conflict_monitor.sv
src/mpmem_top.sv
verif/mpmem_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
cd "$(dirname "$0")" &&
verilator --binary --timing --assert --timescale 1ns/1ps \
  --top-module mpmem_tb -f filelist.f -o mpmem_sim &&
./obj_dir/mpmem_sim | tee /dev/stderr | grep -F "SIMULATION PASSED" > /dev/null &&
echo "run passed" ||
{ echo "run failed"; exit 1; }
